//--- Bender.yml
package:
  name: byte_ram

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - byte_ram_pkg.sv
      - byte_ram_array.sv
      - read_pipe.sv
      - init_counter.sv
      - init_fsm.sv
      - byte_ram.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_byte_ram.sv

//--- byte_ram.f
+incdir+.
byte_ram_pkg.sv
byte_ram_array.sv
read_pipe.sv
init_counter.sv
init_fsm.sv
byte_ram.sv
tb_byte_ram.sv

//--- byte_ram.sv
// Top level of the byte-masked dual-port RAM with fill on reset and scrub
// Reads return after 1 + BYTE_RAM_OUT_STAGES edges and rdy marks the end of each fill

`default_nettype none

`include "byte_ram_settings.svh"

module byte_ram
(
    input  logic                   clk1,
    input  logic                   reset,
    input  logic                   scrub,
    output logic                   rdy,

    // Port 0
    input  byte_ram_pkg::addr_t    addr0,
    input  logic                   wen0,
    input  byte_ram_pkg::byteena_t byteena0,
    input  byte_ram_pkg::word_t    wdata0,
    output byte_ram_pkg::word_t    rdata0,

    // Port 1
    input  byte_ram_pkg::addr_t    addr1,
    input  logic                   wen1,
    input  byte_ram_pkg::byteena_t byteena1,
    input  byte_ram_pkg::word_t    wdata1,
    output byte_ram_pkg::word_t    rdata1
);

    import byte_ram_pkg::*;

    // Fill control between the state machine, the counter and the array
    logic  clearing;
    addr_t sweep_addr;
    logic  sweep_last;

    // Raw words from the array read registers
    word_t rword0;
    word_t rword1;

    init_fsm u_fsm
    (
        .clk1       (clk1),
        .reset      (reset),
        .scrub      (scrub),
        .sweep_last (sweep_last),
        .clearing   (clearing),
        .rdy        (rdy)
    );

    init_counter u_counter
    (
        .clk1       (clk1),
        .reset      (reset),
        .clearing   (clearing),
        .sweep_addr (sweep_addr),
        .sweep_last (sweep_last)
    );

    byte_ram_array u_array
    (
        .clk1       (clk1),
        .clearing   (clearing),
        .sweep_addr (sweep_addr),
        .addr0      (addr0),
        .addr1      (addr1),
        .wen0       (wen0),
        .wen1       (wen1),
        .byteena0   (byteena0),
        .byteena1   (byteena1),
        .wdata0     (wdata0),
        .wdata1     (wdata1),
        .rword0     (rword0),
        .rword1     (rword1)
    );

    // One output pipe per read port
    read_pipe #(.N_STAGES(`BYTE_RAM_OUT_STAGES)) u_pipe0
    (
        .clk1 (clk1),
        .din  (rword0),
        .dout (rdata0)
    );

    read_pipe #(.N_STAGES(`BYTE_RAM_OUT_STAGES)) u_pipe1
    (
        .clk1 (clk1),
        .din  (rword1),
        .dout (rdata1)
    );

endmodule

`default_nettype wire

//--- byte_ram_array.sv
// Storage array with two byte-masked write ports and two registered read ports
// During a fill the sweep takes over the port 1 write path and port 0 writes are held off

`default_nettype none

`include "byte_ram_settings.svh"

module byte_ram_array
(
    input  logic                   clk1,
    input  logic                   clearing,
    input  byte_ram_pkg::addr_t    sweep_addr,
    input  byte_ram_pkg::addr_t    addr0,
    input  byte_ram_pkg::addr_t    addr1,
    input  logic                   wen0,
    input  logic                   wen1,
    input  byte_ram_pkg::byteena_t byteena0,
    input  byte_ram_pkg::byteena_t byteena1,
    input  byte_ram_pkg::word_t    wdata0,
    input  byte_ram_pkg::word_t    wdata1,
    output byte_ram_pkg::word_t    rword0,
    output byte_ram_pkg::word_t    rword1
);

    import byte_ram_pkg::*;

    localparam int lane_bits = `BYTE_RAM_BYTE_BITS;

    // The word storage itself
    word_t mem [`BYTE_RAM_ENTRIES];

    // Effective write controls after the fill takeover
    logic     wr0_en;
    logic     wr1_en;
    addr_t    wr1_addr;
    byteena_t wr1_be;
    word_t    wr1_data;

    // Port 0 is simply blocked while the sweep runs
    assign wr0_en = wen0 && !clearing;

    // Port 1 write path is replaced by the sweep during a fill
    // The sweep always writes a full word of the fill value
    assign wr1_en   = clearing || wen1;
    assign wr1_addr = clearing ? sweep_addr : addr1;
    assign wr1_be   = clearing ? '1 : byteena1;
    assign wr1_data = clearing ? word_t'(`BYTE_RAM_INIT_VALUE) : wdata1;

    // Per-lane writes from both ports
    // Port 1 is applied after port 0, so it wins any lane that both enable on one address
    // Lanes enabled by only one port land from that port
    always_ff @(posedge clk1)
    begin
        for (int i = 0; i < n_bytes; i++)
        begin
            if (wr0_en && byteena0[i])
            begin
                mem[addr0][i*lane_bits +: lane_bits] <= wdata0[i*lane_bits +: lane_bits];
            end
            if (wr1_en && wr1_be[i])
            begin
                mem[wr1_addr][i*lane_bits +: lane_bits] <= wr1_data[i*lane_bits +: lane_bits];
            end
        end
    end

    // Read registers for both ports
    // The array is sampled before this edge's writes, so a colliding read sees the old word
    // Port 1 keeps reading at addr1 during a fill and sees whatever the sweep has reached
    always_ff @(posedge clk1)
    begin
        rword0 <= mem[addr0];
        rword1 <= mem[addr1];
    end

    // A port 0 write offered during a fill must leave its target word untouched
    // The sweep address is excluded since the fill itself rewrites that word
    a_no_wr0_in_fill: assert property (
        @(posedge clk1)
        clearing && wen0 && (addr0 != sweep_addr)
        |=> mem[$past(addr0)] === $past(mem[addr0])
    )
    else $error("port 0 write landed while the fill was running");

    // Same rule for port 1, whose write path belongs to the sweep during a fill
    a_no_wr1_in_fill: assert property (
        @(posedge clk1)
        clearing && wen1 && (addr1 != sweep_addr)
        |=> mem[$past(addr1)] === $past(mem[addr1])
    )
    else $error("port 1 write landed while the fill was running");

endmodule

`default_nettype wire

//--- byte_ram_pkg.sv
// Shared types for the byte-masked dual-port RAM
// Every RTL module imports this package for its address, word and enable types

`default_nettype none

`include "byte_ram_settings.svh"

package byte_ram_pkg;

    // Byte lanes in one word
    localparam int n_bytes = `BYTE_RAM_DATA_BITS / `BYTE_RAM_BYTE_BITS;

    // Word address wide enough to index every entry
    typedef logic [$clog2(`BYTE_RAM_ENTRIES)-1:0] addr_t;

    // One data word as stored and returned by the array
    typedef logic [`BYTE_RAM_DATA_BITS-1:0] word_t;

    // One write enable bit per byte lane
    // Bit i covers word bits [i*BYTE_BITS +: BYTE_BITS]
    typedef logic [n_bytes-1:0] byteena_t;

    // States of the fill controller
    // CLEAR sweeps the fill value through the array and READY is normal operation
    typedef enum logic
    {
        CLEAR,
        READY
    } fill_state_t;

endpackage

`default_nettype wire

//--- byte_ram_settings.svh
// Build-time sizing for the byte-masked dual-port RAM
// Include this wherever the depth, widths, stage count or fill value are needed

`ifndef BYTE_RAM_SETTINGS_SVH
`define BYTE_RAM_SETTINGS_SVH

// Number of words held by the array
`define BYTE_RAM_ENTRIES 64

// Width of one data word in bits
`define BYTE_RAM_DATA_BITS 32

// Width of one byte lane in bits
// The word width must be a whole multiple of this
`define BYTE_RAM_BYTE_BITS 8

// Extra output register stages after the array read register
// Read latency is one more than this
`define BYTE_RAM_OUT_STAGES 1

// Constant written to every word by the fill after reset or a scrub
`define BYTE_RAM_INIT_VALUE 32'hdeadbeef

`endif

//--- init_counter.sv
// Address sweep used by the fill
// Counts through every entry once per cycle while clearing is high and flags the last one

`default_nettype none

`include "byte_ram_settings.svh"

module init_counter
(
    input  logic                clk1,
    input  logic                reset,
    input  logic                clearing,
    output byte_ram_pkg::addr_t sweep_addr,
    output logic                sweep_last
);

    import byte_ram_pkg::*;

    // Highest entry index in the array
    localparam addr_t top_entry = addr_t'(`BYTE_RAM_ENTRIES - 1);

    addr_t count;

    // Holds at zero between fills so the next sweep starts at entry 0
    // The explicit wrap keeps a depth that is not a power of two in range
    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (!clearing || (count == top_entry))
        begin
            count <= '0;
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    assign sweep_addr = count;

    // Only meaningful while a fill is running
    assign sweep_last = clearing && (count == top_entry);

    // The sweep must stay inside the array
    a_count_in_range: assert property (
        @(posedge clk1) disable iff (reset)
        count <= top_entry
    )
    else $error("sweep address ran past the top entry");

endmodule

`default_nettype wire

//--- init_fsm.sv
// Fill and ready controller for the RAM
// Starts a sweep after reset or an accepted scrub and raises rdy when the sweep ends

`default_nettype none

module init_fsm
(
    input  logic clk1,
    input  logic reset,
    input  logic scrub,
    input  logic sweep_last,
    output logic clearing,
    output logic rdy
);

    import byte_ram_pkg::*;

    fill_state_t state_q;
    fill_state_t state_d;

    // Next state
    // A scrub is only taken in READY, so one arriving mid-fill is dropped
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            CLEAR:
            begin
                if (sweep_last)
                begin
                    state_d = READY;
                end
            end
            READY:
            begin
                if (scrub)
                begin
                    state_d = CLEAR;
                end
            end
        endcase
    end

    // State plus registered decodes of it
    // Decoding from the next state keeps clearing and rdy aligned with the state register
    // Reset leaves clearing high so the sweep starts in the first cycle out of reset
    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            state_q  <= CLEAR;
            clearing <= 1'b1;
            rdy      <= 1'b0;
        end
        else
        begin
            state_q  <= state_d;
            clearing <= (state_d == CLEAR);
            rdy      <= (state_d == READY);
        end
    end

    // The array must never be reported ready while the sweep owns it
    a_rdy_not_clearing: assert property (
        @(posedge clk1) disable iff (reset)
        !(rdy && clearing)
    )
    else $error("rdy and clearing were high together");

    // Ready is sticky and only a reset or a scrub may pull it down
    a_rdy_sticky: assert property (
        @(posedge clk1) disable iff (reset)
        $fell(rdy) |-> $past(scrub) || $past(reset)
    )
    else $error("rdy fell without a reset or a scrub");

endmodule

`default_nettype wire

//--- read_pipe.sv
// Extra output register stages for one read port of the RAM
// Set N_STAGES to ease timing after the array; zero passes the word straight through

`default_nettype none

module read_pipe
#(
    parameter int N_STAGES = 1
)
(
    input  logic                clk1,
    input  byte_ram_pkg::word_t din,
    output byte_ram_pkg::word_t dout
);

    import byte_ram_pkg::*;

    generate
        if (N_STAGES == 0)
        begin : g_bypass
            // No extra delay is requested
            assign dout = din;
        end
        else
        begin : g_stages
            // Stage 0 takes the raw array word and the last stage drives the port
            word_t stage_q [N_STAGES];

            always_ff @(posedge clk1)
            begin
                stage_q[0] <= din;
                for (int s = 1; s < N_STAGES; s++)
                begin
                    stage_q[s] <= stage_q[s-1];
                end
            end

            assign dout = stage_q[N_STAGES-1];
        end
    endgenerate

endmodule

`default_nettype wire

//--- tb_byte_ram.sv
// Directed testbench for the byte-masked dual-port RAM
// Runs the fill, masked write, pipelined read, collision and scrub tests against a shadow array
// Drives on the rising edge and samples DUT outputs on the falling edge

`default_nettype none

`include "byte_ram_settings.svh"

module tb_byte_ram;

    timeunit 1ns;
    timeprecision 1ps;

    import byte_ram_pkg::*;

    localparam int entries    = `BYTE_RAM_ENTRIES;
    localparam int lat        = 1 + `BYTE_RAM_OUT_STAGES;
    localparam int clk_period = 4;
    localparam int n_writes   = 16;
    localparam int n_collide  = 8;

    // Rough cycle budget of every test, summed for the watchdog
    localparam int test_cycles = (8 + entries + 1 + entries + lat)
                               + n_writes * (3 + lat + 1)
                               + (entries + lat)
                               + n_collide * (4 + lat + 1 + lat)
                               + (3 + entries + entries + lat);
    localparam int watchdog_ns = (test_cycles * 2 + 200) * clk_period;

    logic     clk1;
    logic     reset;
    logic     scrub;
    logic     rdy;
    addr_t    addr0;
    logic     wen0;
    byteena_t byteena0;
    word_t    wdata0;
    word_t    rdata0;
    addr_t    addr1;
    logic     wen1;
    byteena_t byteena1;
    word_t    wdata1;
    word_t    rdata1;

    // Expected contents of the array
    word_t  shadow [entries];
    integer seed = 32'h8ab9a8a1;
    int     error_count = 0;

    byte_ram u_dut
    (
        .clk1     (clk1),
        .reset    (reset),
        .scrub    (scrub),
        .rdy      (rdy),
        .addr0    (addr0),
        .wen0     (wen0),
        .byteena0 (byteena0),
        .wdata0   (wdata0),
        .rdata0   (rdata0),
        .addr1    (addr1),
        .wen1     (wen1),
        .byteena1 (byteena1),
        .wdata1   (wdata1),
        .rdata1   (rdata1)
    );

    initial
    begin
        clk1 = 1'b0;
        forever #(clk_period / 2) clk1 = ~clk1;
    end

    // Stops a hung run
    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within the expected time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input string test, input word_t expected, input word_t actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch in %s", test);
        end
    endtask

    // Lanes with an enable bit take the new data, the rest keep the old word
    function automatic word_t merge_lanes(word_t old, byteena_t be, word_t data);
        word_t result;
        result = old;
        for (int i = 0; i < n_bytes; i++)
        begin
            if (be[i])
            begin
                result[i*`BYTE_RAM_BYTE_BITS +: `BYTE_RAM_BYTE_BITS] =
                    data[i*`BYTE_RAM_BYTE_BITS +: `BYTE_RAM_BYTE_BITS];
            end
        end
        return result;
    endfunction

    task automatic fill_shadow();
        for (int i = 0; i < entries; i++)
        begin
            shadow[i] = `BYTE_RAM_INIT_VALUE;
        end
    endtask

    // Counts cycles after the rdy-dropping edge and expects rdy back after exactly entries
    task automatic expect_fill(input string test);
        check(test, word_t'(1'b0), word_t'(rdy));
        for (int i = 1; i <= entries; i++)
        begin
            @(posedge clk1);
            @(negedge clk1);
            check(test, word_t'(i == entries), word_t'(rdy));
        end
    endtask

    // One read on each port, checked lat edges after the address is taken
    task automatic read_check(input string test, input addr_t a0, input addr_t a1);
        @(posedge clk1);
        addr0 <= a0;
        addr1 <= a1;
        repeat (lat) @(posedge clk1);
        @(negedge clk1);
        check(test, shadow[a0], rdata0);
        check(test, shadow[a1], rdata1);
    endtask

    // A new address every cycle on both ports, checked against the address sent lat cycles back
    task automatic stream_read(input string test, input bit random_addr);
        addr_t q0 [$];
        addr_t q1 [$];
        addr_t a0;
        addr_t a1;
        for (int j = 0; j < entries + lat; j++)
        begin
            @(posedge clk1);
            if (j < entries)
            begin
                a0 = random_addr ? addr_t'($random(seed)) : addr_t'(j);
                a1 = random_addr ? addr_t'($random(seed)) : addr_t'(entries - 1 - j);
                addr0 <= a0;
                addr1 <= a1;
                q0.push_back(a0);
                q1.push_back(a1);
            end
            @(negedge clk1);
            if (j >= lat)
            begin
                a0 = q0.pop_front();
                a1 = q1.pop_front();
                check(test, shadow[a0], rdata0);
                check(test, shadow[a1], rdata1);
            end
        end
    endtask

    task automatic reset_fill_test();
        repeat (8) @(posedge clk1);
        reset <= 1'b0;
        @(negedge clk1);
        expect_fill("reset_fill");
        fill_shadow();
        stream_read("reset_fill", 1'b0);
    endtask

    // Each port writes a different address, then the other port reads it back
    task automatic masked_write_test();
        addr_t    a0;
        addr_t    a1;
        byteena_t be0;
        byteena_t be1;
        word_t    d0;
        word_t    d1;
        for (int k = 0; k < n_writes; k++)
        begin
            a0  = addr_t'($random(seed));
            a1  = addr_t'($random(seed));
            if (a1 == a0)
            begin
                a1 = a0 + 1'b1;
            end
            be0 = byteena_t'($random(seed));
            be1 = byteena_t'($random(seed));
            d0  = word_t'($random(seed));
            d1  = word_t'($random(seed));
            @(posedge clk1);
            addr0    <= a0;
            addr1    <= a1;
            wen0     <= 1'b1;
            wen1     <= 1'b1;
            byteena0 <= be0;
            byteena1 <= be1;
            wdata0   <= d0;
            wdata1   <= d1;
            @(posedge clk1);
            wen0 <= 1'b0;
            wen1 <= 1'b0;
            shadow[a0] = merge_lanes(shadow[a0], be0, d0);
            shadow[a1] = merge_lanes(shadow[a1], be1, d1);
            read_check("masked_write", a1, a0);
        end
    endtask

    // Both ports write and read one address in the same cycle
    task automatic collision_test();
        addr_t    a;
        byteena_t be0;
        byteena_t be1;
        word_t    d0;
        word_t    d1;
        word_t    old;
        for (int k = 0; k < n_collide; k++)
        begin
            a   = addr_t'($random(seed));
            d0  = word_t'($random(seed));
            d1  = word_t'($random(seed));
            be0 = (k == 0) ? byteena_t'(4'b0011) : byteena_t'($random(seed));
            be1 = (k == 0) ? byteena_t'(4'b0110) : byteena_t'($random(seed));
            old = shadow[a];
            @(posedge clk1);
            addr0    <= a;
            addr1    <= a;
            wen0     <= 1'b1;
            wen1     <= 1'b1;
            byteena0 <= be0;
            byteena1 <= be1;
            wdata0   <= d0;
            wdata1   <= d1;
            @(posedge clk1);
            wen0 <= 1'b0;
            wen1 <= 1'b0;
            repeat (lat - 1) @(posedge clk1);
            @(negedge clk1);
            // The read taken at the write edge sees the word from before it
            check("collision", old, rdata0);
            check("collision", old, rdata1);
            if (k == 0)
            begin
                // Lane 0 from port 0, lanes 1 and 2 from port 1, lane 3 untouched
                shadow[a] = {old[31:24], d1[23:8], d0[7:0]};
            end
            else
            begin
                shadow[a] = merge_lanes(merge_lanes(old, be0, d0), be1, d1);
            end
            read_check("collision", a, a);
        end
    endtask

    // Writes offered during the fill are dropped, so every word ends at the fill value
    task automatic scrub_test();
        @(negedge clk1);
        check("scrub", word_t'(1'b1), word_t'(rdy));
        @(posedge clk1);
        scrub <= 1'b1;
        @(posedge clk1);
        scrub <= 1'b0;
        @(negedge clk1);
        check("scrub", word_t'(1'b0), word_t'(rdy));
        for (int i = 1; i <= entries; i++)
        begin
            @(posedge clk1);
            wen0     <= (i <= entries - 2);
            wen1     <= (i <= entries - 2);
            addr0    <= addr_t'($random(seed));
            addr1    <= addr_t'($random(seed));
            byteena0 <= byteena_t'($random(seed));
            byteena1 <= byteena_t'($random(seed));
            wdata0   <= word_t'($random(seed));
            wdata1   <= word_t'($random(seed));
            @(negedge clk1);
            check("scrub", word_t'(i == entries), word_t'(rdy));
        end
        fill_shadow();
        stream_read("scrub", 1'b0);
    endtask

    initial
    begin
        reset    = 1'b1;
        scrub    = 1'b0;
        addr0    = '0;
        wen0     = 1'b0;
        byteena0 = '0;
        wdata0   = '0;
        addr1    = '0;
        wen1     = 1'b0;
        byteena1 = '0;
        wdata1   = '0;

        reset_fill_test();
        masked_write_test();
        stream_read("pipelined_read", 1'b1);
        collision_test();
        scrub_test();

        if (error_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
